// File: logic/seq_lab_config.svh
`ifndef SEQ_LAB_CONFIG_SVH
`define SEQ_LAB_CONFIG_SVH

// Clock cycles an input has to hold its level before it is accepted
`define SEQ_DEBOUNCE_DEPTH 8

// Step strobe period is 2**SEQ_STROBE_WIDTH clocks, about 0.17 s at 50 MHz
`define SEQ_STROBE_WIDTH 23

// Widths of the step counter and of each hit counter
`define SEQ_STEP_CNT_W 16
`define SEQ_HIT_CNT_W 8

`endif

// File: logic/seq_lab_pkg.sv
`include "seq_lab_config.svh"

package seq_lab_pkg;

    // Moore detector for 1,1,0; the output is a function of the state alone
    typedef enum logic [1:0] {
        MOORE_IDLE,
        MOORE_ONE,
        MOORE_ONE_ONE,
        MOORE_HIT
    } moore_state_t;

    // Mealy detector for 1,0,1; the hit also depends on the current tap bit
    typedef enum logic [1:0] {
        MEALY_IDLE,
        MEALY_ONE,
        MEALY_ONE_ZERO
    } mealy_state_t;

    // Counts shown on the seven-segment display
    typedef logic [`SEQ_HIT_CNT_W-1:0]  hit_count_t;
    typedef logic [`SEQ_STEP_CNT_W-1:0] step_count_t;

endpackage

// File: logic/detect_if.sv
`timescale 1ns/1ps

interface detect_if;

    // Single-cycle step pulse shared by the shifter, the detectors and the counters
    logic step;
    // Bit leaving the shift register
    logic tap;
    logic moore_hit;
    logic mealy_hit;

    modport ctrl (
        output step,
        output moore_hit,
        output mealy_hit,
        input  tap
    );

    modport shifter (
        input  step,
        output tap
    );

    modport counters (
        input step,
        input tap,
        input moore_hit,
        input mealy_hit
    );

endinterface

// File: logic/input_conditioner.sv
`timescale 1ns/1ps
`include "seq_lab_config.svh"

module input_conditioner #(
    parameter int p_width = 1
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic [p_width-1:0] i_raw,
    output logic [p_width-1:0] o_clean
);

    localparam int lp_depth = `SEQ_DEBOUNCE_DEPTH;
    localparam int lp_cnt_w = $clog2(lp_depth + 1);

    logic [p_width-1:0]  sync_meta;
    logic [p_width-1:0]  sync_q;
    logic [p_width-1:0]  clean_q;
    logic [lp_cnt_w-1:0] stable_cnt [p_width];

    // Two flops per bit bring the asynchronous inputs into the clock domain
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= i_raw;
            sync_q    <= sync_meta;
        end
    end

    // Each bit counts samples that disagree with the accepted level.
    // Any sample that agrees again restarts the count
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            clean_q <= '0;
            for (int i = 0; i < p_width; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < p_width; i++) begin
                if (sync_q[i] == clean_q[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == lp_cnt_w'(lp_depth - 1)) begin
                    clean_q[i]    <= sync_q[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign o_clean = clean_q;

endmodule

// File: logic/seq_detect_ctrl.sv
`timescale 1ns/1ps
`include "seq_lab_config.svh"

module seq_detect_ctrl #(
    parameter int p_strobe_width = `SEQ_STROBE_WIDTH
) (
    input  logic   i_clk,
    input  logic   i_rst,
    detect_if.ctrl det
);
    import seq_lab_pkg::*;

    logic [p_strobe_width-1:0] strobe_cnt;
    logic                      step_q;
    moore_state_t              moore_state;
    moore_state_t              moore_next;
    mealy_state_t              mealy_state;
    mealy_state_t              mealy_next;

    // Free-running counter; step is registered on the wrap, so it is one cycle wide
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            strobe_cnt <= '0;
            step_q     <= 1'b0;
        end else begin
            strobe_cnt <= strobe_cnt + 1'b1;
            step_q     <= &strobe_cnt;
        end
    end

    assign det.step = step_q;

    // Moore machine for 1,1,0 with overlap, a trailing 1 restarts the match
    always_comb begin
        moore_next = moore_state;
        if (step_q) begin
            case (moore_state)
                MOORE_IDLE:    moore_next = det.tap ? MOORE_ONE     : MOORE_IDLE;
                MOORE_ONE:     moore_next = det.tap ? MOORE_ONE_ONE : MOORE_IDLE;
                MOORE_ONE_ONE: moore_next = det.tap ? MOORE_ONE_ONE : MOORE_HIT;
                MOORE_HIT:     moore_next = det.tap ? MOORE_ONE     : MOORE_IDLE;
                default:       moore_next = MOORE_IDLE;
            endcase
        end
    end

    // Mealy machine for 1,0,1; the final 1 also starts the next pattern
    always_comb begin
        mealy_next = mealy_state;
        if (step_q) begin
            case (mealy_state)
                MEALY_IDLE:     mealy_next = det.tap ? MEALY_ONE : MEALY_IDLE;
                MEALY_ONE:      mealy_next = det.tap ? MEALY_ONE : MEALY_ONE_ZERO;
                MEALY_ONE_ZERO: mealy_next = det.tap ? MEALY_ONE : MEALY_IDLE;
                default:        mealy_next = MEALY_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            moore_state <= MOORE_IDLE;
            mealy_state <= MEALY_IDLE;
        end else begin
            moore_state <= moore_next;
            mealy_state <= mealy_next;
        end
    end

    assign det.moore_hit = (moore_state == MOORE_HIT);

    // Only valid in the step cycle, when the tap bit is the one being consumed
    assign det.mealy_hit = step_q & det.tap & (mealy_state == MEALY_ONE_ZERO);

endmodule

// File: logic/bit_shifter.sv
`timescale 1ns/1ps

module bit_shifter (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_serial,
    detect_if.shifter   det,
    output logic [9:0]  o_bits
);

    logic [9:0] shift_q;

    // New bit enters at the top and the register moves towards bit 0
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            shift_q <= '0;
        end else if (det.step) begin
            shift_q <= {i_serial, shift_q[9:1]};
        end
    end

    // Bit 0 is the oldest sample and feeds both detectors
    assign det.tap = shift_q[0];
    assign o_bits  = shift_q;

endmodule

// File: logic/event_counters.sv
`timescale 1ns/1ps

module event_counters (
    input  logic                      i_clk,
    input  logic                      i_rst,
    detect_if.counters                det,
    output seq_lab_pkg::step_count_t  o_step_count,
    output seq_lab_pkg::hit_count_t   o_moore_count,
    output seq_lab_pkg::hit_count_t   o_mealy_count
);
    import seq_lab_pkg::*;

    step_count_t step_cnt;
    hit_count_t  moore_cnt;
    hit_count_t  mealy_cnt;

    // All three counters wrap silently at their width
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            step_cnt  <= '0;
            moore_cnt <= '0;
            mealy_cnt <= '0;
        end else if (det.step) begin
            step_cnt <= step_cnt + 1'b1;
            if (det.moore_hit) begin
                moore_cnt <= moore_cnt + 1'b1;
            end
            if (det.mealy_hit) begin
                mealy_cnt <= mealy_cnt + 1'b1;
            end
        end
    end

    assign o_step_count  = step_cnt;
    assign o_moore_count = moore_cnt;
    assign o_mealy_count = mealy_cnt;

endmodule

// File: logic/hex_display.sv
`timescale 1ns/1ps

module hex_display (
    input  seq_lab_pkg::step_count_t i_step_count,
    input  seq_lab_pkg::hit_count_t  i_moore_count,
    input  seq_lab_pkg::hit_count_t  i_mealy_count,
    input  logic [5:0]               i_dp,
    output logic [7:0]               o_hex0,
    output logic [7:0]               o_hex1,
    output logic [7:0]               o_hex2,
    output logic [7:0]               o_hex3,
    output logic [7:0]               o_hex4,
    output logic [7:0]               o_hex5
);

    logic [23:0] nibbles;

    // Segment order is g..a in bits 6 to 0, lit when low
    function automatic logic [6:0] seg_decode(input logic [3:0] value);
        case (value)
            4'h0: seg_decode = 7'b1000000;
            4'h1: seg_decode = 7'b1111001;
            4'h2: seg_decode = 7'b0100100;
            4'h3: seg_decode = 7'b0110000;
            4'h4: seg_decode = 7'b0011001;
            4'h5: seg_decode = 7'b0010010;
            4'h6: seg_decode = 7'b0000010;
            4'h7: seg_decode = 7'b1111000;
            4'h8: seg_decode = 7'b0000000;
            4'h9: seg_decode = 7'b0010000;
            4'ha: seg_decode = 7'b0001000;
            4'hb: seg_decode = 7'b0000011;
            4'hc: seg_decode = 7'b1000110;
            4'hd: seg_decode = 7'b0100001;
            4'he: seg_decode = 7'b0000110;
            default: seg_decode = 7'b0001110;
        endcase
    endfunction

    // Only the low byte of the step count fits on the two top digits
    assign nibbles = {i_step_count[7:0], i_moore_count[7:0], i_mealy_count[7:0]};

    // Decimal points are active low as well
    assign o_hex0 = {~i_dp[0], seg_decode(nibbles[3:0])};
    assign o_hex1 = {~i_dp[1], seg_decode(nibbles[7:4])};
    assign o_hex2 = {~i_dp[2], seg_decode(nibbles[11:8])};
    assign o_hex3 = {~i_dp[3], seg_decode(nibbles[15:12])};
    assign o_hex4 = {~i_dp[4], seg_decode(nibbles[19:16])};
    assign o_hex5 = {~i_dp[5], seg_decode(nibbles[23:20])};

endmodule

// File: logic/seq_lab_top.sv
`timescale 1ns/1ps
`include "seq_lab_config.svh"

module seq_lab_top #(
    parameter int p_strobe_width = `SEQ_STROBE_WIDTH
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic [1:0] i_key,
    input  logic [9:0] i_sw,
    output logic [9:0] o_led,
    output logic [7:0] o_hex0,
    output logic [7:0] o_hex1,
    output logic [7:0] o_hex2,
    output logic [7:0] o_hex3,
    output logic [7:0] o_hex4,
    output logic [7:0] o_hex5
);
    import seq_lab_pkg::*;

    logic [1:0]  key_db;
    logic [9:0]  sw_db;
    step_count_t step_count;
    hit_count_t  moore_count;
    hit_count_t  mealy_count;

    detect_if det ();

    // Keys are active low on the board, so they are inverted before conditioning
    input_conditioner #(.p_width(2)) u_key_cond (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_raw   (~i_key),
        .o_clean (key_db)
    );

    input_conditioner #(.p_width(10)) u_sw_cond (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_raw   (i_sw),
        .o_clean (sw_db)
    );

    seq_detect_ctrl #(.p_strobe_width(p_strobe_width)) u_ctrl (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .det   (det.ctrl)
    );

    bit_shifter u_shifter (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_serial (key_db[1]),
        .det      (det.shifter),
        .o_bits   (o_led)
    );

    event_counters u_counters (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .det           (det.counters),
        .o_step_count  (step_count),
        .o_moore_count (moore_count),
        .o_mealy_count (mealy_count)
    );

    hex_display u_display (
        .i_step_count  (step_count),
        .i_moore_count (moore_count),
        .i_mealy_count (mealy_count),
        .i_dp          (sw_db[5:0]),
        .o_hex0        (o_hex0),
        .o_hex1        (o_hex1),
        .o_hex2        (o_hex2),
        .o_hex3        (o_hex3),
        .o_hex4        (o_hex4),
        .o_hex5        (o_hex5)
    );

endmodule

// File: bench/seq_lab_sva.sv
`timescale 1ns/1ps

module seq_lab_sva (
    input logic                      i_clk,
    input logic                      i_rst,
    input logic                      i_step,
    input logic                      i_moore_hit,
    input seq_lab_pkg::moore_state_t i_moore_state
);
    import seq_lab_pkg::*;

    // Number of assertion failures so far, read by the testbench at the end of the run
    int assert_failures;

    initial begin
        assert_failures = 0;
    end

    // The strobe is a pulse and two steps never follow back to back
    a_step_single: assert property (
        @(posedge i_clk) disable iff (i_rst) i_step |=> !i_step
    ) else begin
        $error("step stayed high for more than one cycle");
        assert_failures++;
    end

    // Reset clears the strobe by the next edge and keeps it low
    a_step_reset: assert property (
        @(posedge i_clk) i_rst |=> !i_step
    ) else begin
        $error("step went high while reset was asserted");
        assert_failures++;
    end

    a_moore_hit_state: assert property (
        @(posedge i_clk) disable iff (i_rst) i_moore_hit |-> (i_moore_state == MOORE_HIT)
    ) else begin
        $error("moore_hit high outside MOORE_HIT");
        assert_failures++;
    end

endmodule

bind seq_detect_ctrl seq_lab_sva u_sva (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_step        (det.step),
    .i_moore_hit   (det.moore_hit),
    .i_moore_state (moore_state)
);

// File: bench/seq_lab_tb.sv
`timescale 1ns/1ps

module seq_lab_tb;
    import seq_lab_pkg::*;

    logic       clk;
    logic       rst;
    logic [1:0] key;
    logic [9:0] sw;
    logic [9:0] led;
    logic [7:0] hex [6];

    int errors;
    int compares;
    int tests;
    int failed_tests;
    bit aborted;

    seq_lab_top #(.p_strobe_width(5)) i_dut (
        .i_clk  (clk),
        .i_rst  (rst),
        .i_key  (key),
        .i_sw   (sw),
        .o_led  (led),
        .o_hex0 (hex[0]),
        .o_hex1 (hex[1]),
        .o_hex2 (hex[2]),
        .o_hex3 (hex[3]),
        .o_hex4 (hex[4]),
        .o_hex5 (hex[5])
    );

    always #2 clk = ~clk;

    // Segments g..a sit in bits 6 to 0 and light when low.
    // Bit 4 of the result marks a pattern that is no hex digit
    function automatic logic [4:0] seg_to_nibble(input logic [6:0] seg);
        case (seg)
            7'h40: return 5'h00;
            7'h79: return 5'h01;
            7'h24: return 5'h02;
            7'h30: return 5'h03;
            7'h19: return 5'h04;
            7'h12: return 5'h05;
            7'h02: return 5'h06;
            7'h78: return 5'h07;
            7'h00: return 5'h08;
            7'h10: return 5'h09;
            7'h08: return 5'h0a;
            7'h03: return 5'h0b;
            7'h46: return 5'h0c;
            7'h21: return 5'h0d;
            7'h06: return 5'h0e;
            7'h0e: return 5'h0f;
            default: return 5'h10;
        endcase
    endfunction

    // A decimal point is lit when its bit is low
    function automatic logic [5:0] dp_lit();
        return ~{hex[5][7], hex[4][7], hex[3][7], hex[2][7], hex[1][7], hex[0][7]};
    endfunction

    task automatic read_pair(input int hi, input int lo, output hit_count_t value);
        logic [4:0] h;
        logic [4:0] l;
        h = seg_to_nibble(hex[hi][6:0]);
        l = seg_to_nibble(hex[lo][6:0]);
        if (h[4] || l[4]) begin
            $display("Error at time %0t: digit %0d or %0d shows no hex digit", $time, hi, lo);
            errors++;
        end
        value = {h[3:0], l[3:0]};
    endtask

    task automatic check_led(input logic [9:0] got, input logic [9:0] exp);
        compares++;
        if (got !== exp) begin
            $display("FAIL at time %0t: o_led got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input hit_count_t got, input hit_count_t exp);
        compares++;
        if (got !== exp) begin
            $display("FAIL at time %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_dp(input logic [5:0] got, input logic [5:0] exp);
        compares++;
        if (got !== exp) begin
            $display("FAIL at time %0t: decimal points got %b expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int start);
        tests++;
        if (errors == start) begin
            $display("Test %s: ok", name);
        end else begin
            failed_tests++;
            $display("Test %s: %0d errors", name, errors - start);
        end
    endtask

    // Returns on the falling edge after the step count on digits 5 and 4 moves
    task automatic wait_step();
        hit_count_t first;
        hit_count_t now;
        int cycles;
        read_pair(5, 4, first);
        now = first;
        cycles = 0;
        while (now == first && cycles < 200) begin
            @(negedge clk);
            read_pair(5, 4, now);
            cycles++;
        end
        if (now == first) begin
            $display("Error at time %0t: step count did not change in 200 cycles", $time);
            errors++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        int         fd;
        int         n;
        int         code;
        int         start;
        int         cycles;
        string      line;
        logic       bit_in;
        logic [9:0] exp_led;
        hit_count_t exp_moore;
        hit_count_t exp_mealy;
        hit_count_t got;
        logic [5:0] lit;
        logic [9:0] new_sw;

        void'($urandom(32'h16cf0544));
        clk = 1'b0;
        rst = 1'b1;
        key = 2'b11;
        sw = '0;
        errors = 0;
        compares = 0;
        tests = 0;
        failed_tests = 0;
        aborted = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start = errors;
        check_led(led, '0);
        read_pair(5, 4, got);
        check_count("step count", got, '0);
        read_pair(3, 2, got);
        check_count("moore count", got, '0);
        read_pair(1, 0, got);
        check_count("mealy count", got, '0);
        end_test("reset", start);

        fd = $fopen("bench/seq_lab_vectors.txt", "r");
        if (fd == 0) begin
            $display("Error: the vectors file bench/seq_lab_vectors.txt cannot be opened");
            errors++;
            aborted = 1'b1;
        end
        n = 0;
        while (!aborted && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%h %h %h %h", bit_in, exp_led, exp_moore, exp_mealy);
                if (code == 4) begin
                    n++;
                    start = errors;
                    // Keys are active low at the board pins
                    key[1] = ~bit_in;
                    wait_step();
                    check_led(led, exp_led);
                    read_pair(5, 4, got);
                    check_count("step count", got, hit_count_t'(n));
                    read_pair(3, 2, got);
                    check_count("moore count", got, exp_moore);
                    read_pair(1, 0, got);
                    check_count("mealy count", got, exp_mealy);
                    end_test($sformatf("vector %0d", n), start);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        for (int i = 0; i < 3 && !aborted; i++) begin
            start = errors;
            new_sw = 10'($urandom);
            // A value equal to the current one would leave the decimal points unchanged
            if (new_sw[5:0] == sw[5:0]) begin
                new_sw[5:0] = ~new_sw[5:0];
            end
            sw = new_sw;
            cycles = 0;
            lit = dp_lit();
            while (lit !== sw[5:0] && cycles < 40) begin
                @(negedge clk);
                lit = dp_lit();
                cycles++;
            end
            check_dp(lit, sw[5:0]);
            end_test($sformatf("switches %0d", i), start);
        end

        start = errors;
        if (i_dut.u_ctrl.u_sva.assert_failures != 0) begin
            $display("Error: %0d assertion failures in the control module",
                     i_dut.u_ctrl.u_sva.assert_failures);
            errors++;
        end
        end_test("assertions", start);

        $display("Summary: %0d tests, %0d with errors, %0d compares, %0d errors",
                 tests, failed_tests, compares, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: bench/seq_lab_vectors.txt
# key1_bit led_word moore_count mealy_count, all fields hex
# One line per step, counts are running totals shown after that step
1 200 00 00
1 300 00 00
0 180 00 00
1 2c0 00 00
0 160 00 00
1 2b0 00 00
1 358 00 00
0 1ac 00 00
1 2d6 00 00
0 16b 00 00
0 0b5 00 00
1 25a 00 00
1 32d 00 00
1 396 01 01
0 1cb 01 01
0 0e5 01 02
1 272 01 02
0 139 01 02
1 29c 02 03

// File: seq_lab_top.f
+incdir+logic
logic/seq_lab_pkg.sv
logic/detect_if.sv
logic/input_conditioner.sv
logic/seq_detect_ctrl.sv
logic/bit_shifter.sv
logic/event_counters.sv
logic/hex_display.sv
logic/seq_lab_top.sv
bench/seq_lab_sva.sv
bench/seq_lab_tb.sv
